// ==== hdl/spdif_macros.svh ====
`ifndef SPDIF_MACROS_SVH
`define SPDIF_MACROS_SVH

// control byte layout
`define CTRL_START_BIT 7
`define CTRL_DSD_BIT   6

// word widths
`define SAMPLE_W  32
`define PAYLOAD_W 24

// preamble toggle patterns, one flag per biphase cell
// X starts a left subframe
`define PREAMBLE_X 8'b10010011
// Y starts a right subframe
`define PREAMBLE_Y 8'b10010110
// Z starts the left subframe of frame 0 in a block
`define PREAMBLE_Z 8'b10011100

// DoP marker bytes, alternating frame by frame
`define DOP_MARKER_A 8'hFA
`define DOP_MARKER_B 8'h05

// consumer channel status, sent MSB first one bit per frame
`define CHANNEL_STATUS 24'b001000000000000001000000

// frames per channel status block
`define BLOCK_FRAMES 192

`endif

// ==== hdl/audio_pkg.sv ====
`include "spdif_macros.svh"

package audio_pkg;

    // PCM view, audio in the top bits and the unused low byte below
    typedef struct packed {
        logic [`PAYLOAD_W-1:0]           audio;
        logic [`SAMPLE_W-`PAYLOAD_W-1:0] pad;
    } pcm_view_t;

    // DSD view, the first 16 bits in time sit in hi
    typedef struct packed {
        logic [`SAMPLE_W/2-1:0] hi;
        logic [`SAMPLE_W/2-1:0] lo;
    } dsd_view_t;

    // one received I2S word, read as PCM or as two DoP halves
    typedef union packed {
        pcm_view_t pcm;
        dsd_view_t dsd;
    } sample_word_u;

endpackage

// ==== hdl/i2s_master_clock.sv ====
`timescale 1ns/1ps

module i2s_master_clock (
    input  logic bck,
    input  logic reset_n,
    input  logic run_i,
    output logic bclk_o,
    output logic lrck_o,
    output logic bit_tick_o
);

    // one I2S frame is 128 bck cycles, 64 bit clocks of 2 bck each
    logic [6:0] frame_cnt;

    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            frame_cnt <= '0;
        end else if (!run_i) begin
            frame_cnt <= '0;
        end else begin
            frame_cnt <= frame_cnt + 7'd1;
        end
    end

    // bit clock is high on the odd counts
    assign bclk_o = frame_cnt[0];

    // low half of the frame carries the left word
    assign lrck_o = frame_cnt[6];

    // one pulse per rising bclk edge, data has been stable for a full bck
    assign bit_tick_o = frame_cnt[0];

endmodule

// ==== hdl/i2s32_receiver.sv ====
`timescale 1ns/1ps
`include "spdif_macros.svh"

module i2s32_receiver
    import audio_pkg::*;
(
    input  logic         bck,
    input  logic         reset_n,
    input  logic         run_i,
    input  logic         bit_tick_i,
    input  logic         lrck_i,
    input  logic         sdata_i,
    output sample_word_u pcm_left_o,
    output sample_word_u pcm_right_o,
    output logic         frame_valid_o
);

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_WORK = 1'b1;

    logic                 state;
    logic                 lrck_d;
    logic                 lrck_edge;
    logic [`SAMPLE_W-1:0] shift_q;
    logic [`SAMPLE_W-1:0] word_in;
    logic [`SAMPLE_W-1:0] left_hold;

    // with the one-bit I2S delay, the bit taken on the tick after an lrck
    // change is the LSB of the word that just ended
    assign word_in   = {shift_q[`SAMPLE_W-2:0], sdata_i};
    assign lrck_edge = bit_tick_i & (lrck_i != lrck_d);

    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            state         <= ST_IDLE;
            lrck_d        <= 1'b0;
            frame_valid_o <= 1'b0;
            shift_q       <= '0;
            left_hold     <= '0;
            pcm_left_o    <= '0;
            pcm_right_o   <= '0;
        end else if (!run_i) begin
            state         <= ST_IDLE;
            lrck_d        <= 1'b0;
            frame_valid_o <= 1'b0;
        end else begin
            frame_valid_o <= 1'b0;
            if (bit_tick_i) begin
                lrck_d  <= lrck_i;
                shift_q <= word_in;
            end
            case (state)
                ST_IDLE: begin
                    // lock on the first left word, its MSB comes next bit
                    if (lrck_edge && lrck_d) begin
                        state <= ST_WORK;
                    end
                end
                ST_WORK: begin
                    if (lrck_edge && !lrck_d) begin
                        left_hold <= word_in;
                    end else if (lrck_edge) begin
                        // right word done, publish the pair together
                        pcm_left_o    <= left_hold;
                        pcm_right_o   <= word_in;
                        frame_valid_o <= 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== hdl/dop_packer.sv ====
`timescale 1ns/1ps
`include "spdif_macros.svh"

module dop_packer
    import audio_pkg::*;
(
    input  logic                  bck,
    input  logic                  reset_n,
    input  logic                  run_i,
    input  logic                  use_dsd_i,
    input  logic                  frame_start_i,
    input  sample_word_u          pcm_left_i,
    input  sample_word_u          pcm_right_i,
    output logic [`PAYLOAD_W-1:0] payload_left_o,
    output logic [`PAYLOAD_W-1:0] payload_right_o
);

    // half_lo set means the next frame sends the lo halves
    logic         half_lo;
    logic [7:0]   marker;
    logic [7:0]   marker_next;
    sample_word_u held_left;
    sample_word_u held_right;

    assign marker_next = (marker == `DOP_MARKER_A) ? `DOP_MARKER_B : `DOP_MARKER_A;

    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            half_lo         <= 1'b0;
            marker          <= `DOP_MARKER_A;
            payload_left_o  <= '0;
            payload_right_o <= '0;
        end else if (!run_i) begin
            half_lo         <= 1'b0;
            marker          <= `DOP_MARKER_A;
            payload_left_o  <= '0;
            payload_right_o <= '0;
        end else if (frame_start_i) begin
            if (!use_dsd_i) begin
                half_lo         <= 1'b0;
                marker          <= `DOP_MARKER_A;
                payload_left_o  <= pcm_left_i.pcm.audio;
                payload_right_o <= pcm_right_i.pcm.audio;
            end else if (!half_lo) begin
                half_lo         <= 1'b1;
                marker          <= marker_next;
                payload_left_o  <= {marker, pcm_left_i.dsd.hi};
                payload_right_o <= {marker, pcm_right_i.dsd.hi};
            end else begin
                half_lo         <= 1'b0;
                marker          <= marker_next;
                payload_left_o  <= {marker, held_left.dsd.lo};
                payload_right_o <= {marker, held_right.dsd.lo};
            end
        end
    end

    // keep the pair whose hi halves went out, lo halves follow next frame
    always_ff @(posedge bck) begin
        if (frame_start_i && use_dsd_i && !half_lo) begin
            held_left  <= pcm_left_i;
            held_right <= pcm_right_i;
        end
    end

endmodule

// ==== hdl/spdif_tx.sv ====
`timescale 1ns/1ps
`include "spdif_macros.svh"

module spdif_tx (
    input  logic                  bck,
    input  logic                  reset_n,
    input  logic                  run_i,
    input  logic [`PAYLOAD_W-1:0] payload_left_i,
    input  logic [`PAYLOAD_W-1:0] payload_right_i,
    output logic                  frame_start_o,
    output logic                  spdif_o
);

    // subframes 0..383, even ones are left
    localparam logic [8:0] SUB_LAST = 9'(2 * `BLOCK_FRAMES - 1);

    logic [5:0]            cell_cnt;
    logic [8:0]            sub_cnt;
    logic [`PAYLOAD_W-1:0] din;
    logic [23:0]           cs_shift;
    logic                  parity;
    logic [7:0]            preamble;
    logic [7:0]            toggle_q;
    logic                  line_q;

    // LSB first, each bit becomes a clock toggle then a data toggle
    function automatic logic [7:0] bits_to_toggles(input logic [3:0] b);
        return {1'b1, b[0], 1'b1, b[1], 1'b1, b[2], 1'b1, b[3]};
    endfunction

    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            cell_cnt <= '0;
            sub_cnt  <= '0;
        end else if (!run_i) begin
            cell_cnt <= '0;
            sub_cnt  <= '0;
        end else begin
            cell_cnt <= cell_cnt + 6'd1;
            if (cell_cnt == 6'd63) begin
                if (sub_cnt == SUB_LAST) begin
                    sub_cnt <= '0;
                end else begin
                    sub_cnt <= sub_cnt + 9'd1;
                end
            end
        end
    end

    // packer refreshes its outputs one cycle ahead of the left latch
    assign frame_start_o = (cell_cnt == 6'd1) & ~sub_cnt[0];

    always_ff @(posedge bck) begin
        if (run_i && cell_cnt == 6'd2) begin
            din <= sub_cnt[0] ? payload_right_i : payload_left_i;
        end
    end

    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            cs_shift <= '0;
            parity   <= 1'b0;
        end else if (!run_i) begin
            cs_shift <= '0;
            parity   <= 1'b0;
        end else begin
            // one status bit per frame, reloaded at block start
            if (cell_cnt == 6'd0) begin
                if (sub_cnt == 9'd0) begin
                    cs_shift <= `CHANNEL_STATUS;
                end else if (!sub_cnt[0]) begin
                    cs_shift <= {cs_shift[22:0], 1'b0};
                end
            end
            // V and U are zero so only data and C enter the parity
            parity <= ^din ^ cs_shift[23];
        end
    end

    always_comb begin
        if (sub_cnt == 9'd0) begin
            preamble = `PREAMBLE_Z;
        end else if (!sub_cnt[0]) begin
            preamble = `PREAMBLE_X;
        end else begin
            preamble = `PREAMBLE_Y;
        end
    end

    // a new toggle byte every 8 cells, shifted out MSB first in between
    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            toggle_q <= '0;
            line_q   <= 1'b0;
        end else if (!run_i) begin
            toggle_q <= '0;
            line_q   <= 1'b0;
        end else begin
            if (cell_cnt[2:0] == 3'd0) begin
                case (cell_cnt[5:3])
                    3'd0:    toggle_q <= preamble;
                    3'd1:    toggle_q <= bits_to_toggles(din[3:0]);
                    3'd2:    toggle_q <= bits_to_toggles(din[7:4]);
                    3'd3:    toggle_q <= bits_to_toggles(din[11:8]);
                    3'd4:    toggle_q <= bits_to_toggles(din[15:12]);
                    3'd5:    toggle_q <= bits_to_toggles(din[19:16]);
                    3'd6:    toggle_q <= bits_to_toggles(din[23:20]);
                    default: toggle_q <= bits_to_toggles({parity, cs_shift[23], 2'b00});
                endcase
            end else begin
                toggle_q <= {toggle_q[6:0], 1'b0};
            end
            // biphase mark, the line flips on every toggle flag
            line_q <= line_q ^ toggle_q[7];
        end
    end

    assign spdif_o = line_q;

endmodule

// ==== hdl/audio_bridge_top.sv ====
`timescale 1ns/1ps
`include "spdif_macros.svh"

module audio_bridge_top
    import audio_pkg::*;
(
    input  logic       bck,
    input  logic       reset_n,
    input  logic [7:0] ctrl_i,
    input  logic       sdata_i,
    output logic       bclk_o,
    output logic       lrck_o,
    output logic       spdif_o
);

    logic                  run;
    logic                  use_dsd;
    logic                  bit_tick;
    logic                  frame_start;
    sample_word_u          pcm_left;
    sample_word_u          pcm_right;
    logic [`PAYLOAD_W-1:0] payload_left;
    logic [`PAYLOAD_W-1:0] payload_right;

    assign run     = ctrl_i[`CTRL_START_BIT];
    assign use_dsd = ctrl_i[`CTRL_DSD_BIT];

    i2s_master_clock u_clock (
        .bck        (bck),
        .reset_n    (reset_n),
        .run_i      (run),
        .bclk_o     (bclk_o),
        .lrck_o     (lrck_o),
        .bit_tick_o (bit_tick)
    );

    // frame_valid_o only marks the receive latency, nothing here waits on it
    i2s32_receiver u_rx (
        .bck           (bck),
        .reset_n       (reset_n),
        .run_i         (run),
        .bit_tick_i    (bit_tick),
        .lrck_i        (lrck_o),
        .sdata_i       (sdata_i),
        .pcm_left_o    (pcm_left),
        .pcm_right_o   (pcm_right),
        .frame_valid_o ()
    );

    dop_packer u_dop (
        .bck             (bck),
        .reset_n         (reset_n),
        .run_i           (run),
        .use_dsd_i       (use_dsd),
        .frame_start_i   (frame_start),
        .pcm_left_i      (pcm_left),
        .pcm_right_i     (pcm_right),
        .payload_left_o  (payload_left),
        .payload_right_o (payload_right)
    );

    spdif_tx u_spdif (
        .bck             (bck),
        .reset_n         (reset_n),
        .run_i           (run),
        .payload_left_i  (payload_left),
        .payload_right_i (payload_right),
        .frame_start_o   (frame_start),
        .spdif_o         (spdif_o)
    );

endmodule

// ==== tests/audio_bridge_asserts.sv ====
`timescale 1ns/1ps
`include "spdif_macros.svh"

module audio_bridge_asserts (
    input logic                  bck,
    input logic                  reset_n,
    input logic                  run_i,
    input logic                  use_dsd_i,
    input logic                  frame_start_i,
    input logic [`PAYLOAD_W-1:0] payload_left_i,
    input logic [`PAYLOAD_W-1:0] din_i,
    input logic                  lrck_i
);

    logic       lrck_q;
    logic       seen_edge;
    logic [6:0] hold_cnt;

    // cycles since the last word clock change
    always_ff @(posedge bck or negedge reset_n) begin
        if (!reset_n) begin
            lrck_q    <= 1'b0;
            seen_edge <= 1'b0;
            hold_cnt  <= '0;
        end else if (!run_i) begin
            lrck_q    <= 1'b0;
            seen_edge <= 1'b0;
            hold_cnt  <= '0;
        end else begin
            lrck_q <= lrck_i;
            if (lrck_i != lrck_q) begin
                seen_edge <= 1'b1;
                hold_cnt  <= '0;
            end else begin
                hold_cnt <= hold_cnt + 7'd1;
            end
        end
    end

    marker_valid: assert property (@(posedge bck) disable iff (!reset_n)
        (run_i && use_dsd_i && frame_start_i) |=>
        (payload_left_i[23:16] == `DOP_MARKER_A || payload_left_i[23:16] == `DOP_MARKER_B))
        else $error("DoP marker byte is neither FA nor 05");

    // the transmitter holds the packer output taken one cycle after frame start
    latch_follows_start: assert property (@(posedge bck) disable iff (!reset_n)
        (run_i && $past(run_i && frame_start_i)) |=> (din_i == payload_left_i))
        else $error("left payload was not latched one cycle after frame start");

    lrck_hold: assert property (@(posedge bck) disable iff (!reset_n)
        (run_i && seen_edge && lrck_i != lrck_q) |-> (hold_cnt == 7'd63))
        else $error("word clock half frame is not 64 cycles long");

endmodule

bind audio_bridge_top audio_bridge_asserts u_asserts (
    .bck            (bck),
    .reset_n        (reset_n),
    .run_i          (run),
    .use_dsd_i      (use_dsd),
    .frame_start_i  (frame_start),
    .payload_left_i (payload_left),
    .din_i          (u_spdif.din),
    .lrck_i         (lrck_o)
);

// ==== tests/audio_bridge_tb.sv ====
`timescale 1ns/1ps
`include "spdif_macros.svh"

module audio_bridge_tb
    import audio_pkg::*;
();

    localparam int LOCK_FRAMES = 4;
    localparam int N_PAIRS     = 16;
    localparam int TEST_CYCLES = 620 + 2 * (200 + 16 * 128) + 400 * 128
                                 + (2 * N_PAIRS + 10) * 128 + 40000;

    logic         bck;
    logic         reset_n;
    logic [7:0]   ctrl_i;
    logic         sdata_i;
    logic         bclk_o;
    logic         lrck_o;
    logic         spdif_o;
    logic [15:0]  lfsr = 16'd39274;
    sample_word_u tx_left;
    sample_word_u tx_right;
    sample_word_u cur_left;
    sample_word_u cur_right;
    int           frames_sent;
    logic [5:0]   bpos;
    logic         last_lrck;
    bit           dec_en;
    logic         line_prev;
    logic [63:0]  tw;
    logic [23:0]  left_slot;
    logic         left_c;
    logic         left_z;
    logic [23:0]  fl_q[$];
    logic [23:0]  fr_q[$];
    logic         fcl_q[$];
    logic         fcr_q[$];
    logic         fz_q[$];
    logic [31:0]  exp_l[$];
    logic [31:0]  exp_r[$];

    audio_bridge_top u_dut (
        .bck     (bck),
        .reset_n (reset_n),
        .ctrl_i  (ctrl_i),
        .sdata_i (sdata_i),
        .bclk_o  (bclk_o),
        .lrck_o  (lrck_o),
        .spdif_o (spdif_o)
    );

    initial begin
        bck = 1'b0;
        forever #4 bck = ~bck;
    end

    initial begin
        repeat (TEST_CYCLES) @(posedge bck);
        $display("ERROR %0t: watchdog expired before the tests finished", $time);
        $display("Some tests failed");
        $fatal(1);
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], lfsr_step()};
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("ERROR %0t: %s expected %h got %h", $time, name, exp, act);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("ERROR %0t: %s", $time, what);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // serializer, a new bit after each falling bclk, MSB one bit after lrck moves
    always @(posedge bck) begin
        logic [5:0] b;
        logic [6:0] nb;
        if (!ctrl_i[`CTRL_START_BIT]) begin
            bpos      <= 6'd63;
            last_lrck <= 1'b0;
        end else if (bclk_o) begin
            b  = (lrck_o != last_lrck) ? (lrck_o ? 6'd32 : 6'd0) : bpos + 6'd1;
            nb = b + 7'd1;
            bpos      <= b;
            last_lrck <= lrck_o;
            if (nb == 6'd1) begin
                sdata_i     <= tx_left[31];
                cur_left    <= tx_left;
                cur_right   <= tx_right;
                frames_sent <= frames_sent + 1;
            end else if (nb <= 6'd32) begin
                sdata_i <= cur_left[6'd32 - nb];
            end else begin
                sdata_i <= cur_right[5'(6'd0 - nb)];
            end
        end
    end

    // S/PDIF decoder, a preamble can only sit on top of a full subframe window
    always @(negedge bck) begin
        logic        t;
        logic [27:0] bits;
        t         = spdif_o ^ line_prev;
        line_prev = spdif_o;
        if (!dec_en) begin
            tw = '0;
        end else begin
            tw = {tw[62:0], t};
            if (tw[63:56] == `PREAMBLE_X || tw[63:56] == `PREAMBLE_Y ||
                tw[63:56] == `PREAMBLE_Z) begin
                for (int j = 0; j < 28; j++) begin
                    check_true(tw[55 - 2 * j], "biphase clock toggle missing in subframe");
                    bits[j] = tw[54 - 2 * j];
                end
                check_value("spdif_v", 0, bits[24]);
                check_value("spdif_u", 0, bits[25]);
                check_value("spdif_parity", 0, ^bits);
                if (tw[63:56] == `PREAMBLE_Y) begin
                    fl_q.push_back(left_slot);
                    fr_q.push_back(bits[23:0]);
                    fcl_q.push_back(left_c);
                    fcr_q.push_back(bits[26]);
                    fz_q.push_back(left_z);
                end else begin
                    left_slot = bits[23:0];
                    left_c    = bits[26];
                    left_z    = (tw[63:56] == `PREAMBLE_Z);
                end
            end
        end
    end

    task automatic clear_frames();
        fl_q.delete();
        fr_q.delete();
        fcl_q.delete();
        fcr_q.delete();
        fz_q.delete();
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = fl_q.size() + n;
        while (fl_q.size() < target) @(posedge bck);
    endtask

    task automatic check_idle(input int n);
        repeat (n) begin
            @(negedge bck);
            check_value("bclk_o", 0, bclk_o);
            check_value("lrck_o", 0, lrck_o);
            check_value("spdif_o", 0, spdif_o);
        end
    endtask

    task automatic start_stream(input logic [7:0] ctrl);
        clear_frames();
        dec_en = 1'b1;
        @(posedge bck);
        ctrl_i <= ctrl;
    endtask

    // outputs must be low by the second falling edge after the stop
    task automatic stop_stream(input int n);
        dec_en = 1'b0;
        @(posedge bck);
        ctrl_i <= 8'h00;
        @(negedge bck);
        check_idle(n - 1);
    endtask

    task automatic pcm_payload_test();
        tx_left  = rand_word();
        tx_right = rand_word();
        start_stream(8'h80);
        wait_frames(12);
        for (int i = LOCK_FRAMES; i < fl_q.size(); i++) begin
            check_value("x_slot", tx_left.pcm.audio, fl_q[i]);
            check_value("y_slot", tx_right.pcm.audio, fr_q[i]);
        end
    endtask

    task automatic block_test();
        logic [23:0] cs = `CHANNEL_STATUS;
        logic        exp_c;
        int          z0;
        int          zprev;
        int          zcount;
        zcount = 0;
        clear_frames();
        wait_frames(2 * `BLOCK_FRAMES + 10);
        for (int i = 0; i < fz_q.size(); i++) begin
            if (fz_q[i]) begin
                if (zcount > 0) begin
                    check_value("z_spacing", `BLOCK_FRAMES, i - zprev);
                end else begin
                    z0 = i;
                end
                zprev  = i;
                zcount = zcount + 1;
            end
        end
        check_true(zcount >= 2, "fewer than two Z preambles seen in two blocks");
        for (int k = 0; k < `BLOCK_FRAMES; k++) begin
            exp_c = (k < 24) ? cs[23 - k] : 1'b0;
            check_value("c_bit_left", exp_c, fcl_q[z0 + k]);
            check_value("c_bit_right", exp_c, fcr_q[z0 + k]);
        end
    endtask

    task automatic dsd_test();
        int  target;
        int  m;
        int  j;
        bit  found;
        exp_l.delete();
        exp_r.delete();
        tx_left  = rand_word();
        tx_right = rand_word();
        exp_l.push_back(tx_left);
        exp_r.push_back(tx_right);
        start_stream(8'hC0);
        for (int p = 1; p < N_PAIRS; p++) begin
            target = frames_sent + 2;
            while (frames_sent < target) @(posedge bck);
            tx_left  = rand_word();
            tx_right = rand_word();
            exp_l.push_back(tx_left);
            exp_r.push_back(tx_right);
        end
        wait_frames(8);
        for (int i = 0; i < fl_q.size(); i++) begin
            check_value("dop_marker_left", (i % 2) ? 8'h05 : 8'hFA, fl_q[i][23:16]);
            check_value("dop_marker_right", (i % 2) ? 8'h05 : 8'hFA, fr_q[i][23:16]);
        end
        // lock onto one of the first pairs, after that no pair may be skipped
        found = 1'b0;
        m     = 0;
        while (!found && 2 * m + 1 < fl_q.size() && m < 4) begin
            for (int jj = 0; jj < 3; jj++) begin
                if (!found && {fl_q[2 * m][15:0], fl_q[2 * m + 1][15:0]} == exp_l[jj] &&
                    {fr_q[2 * m][15:0], fr_q[2 * m + 1][15:0]} == exp_r[jj]) begin
                    found = 1'b1;
                    j     = jj;
                end
            end
            if (!found) m = m + 1;
        end
        check_true(found, "DoP stream never locked onto a sent word pair");
        while (j < N_PAIRS - 1) begin
            m = m + 1;
            j = j + 1;
            check_true(2 * m + 1 < fl_q.size(), "DoP stream ended before the last word pair");
            check_value("dop_left_word", exp_l[j], {fl_q[2 * m][15:0], fl_q[2 * m + 1][15:0]});
            check_value("dop_right_word", exp_r[j], {fr_q[2 * m][15:0], fr_q[2 * m + 1][15:0]});
        end
    endtask

    initial begin
        reset_n     = 1'b0;
        ctrl_i      = 8'h00;
        sdata_i     = 1'b0;
        frames_sent = 0;
        bpos        = 6'd63;
        last_lrck   = 1'b0;
        dec_en      = 1'b0;
        line_prev   = 1'b0;
        tw          = '0;
        tx_left     = '0;
        tx_right    = '0;
        cur_left    = '0;
        cur_right   = '0;
        repeat (10) @(posedge bck);
        reset_n <= 1'b1;
        check_idle(300);
        // DSD bit alone must not start anything
        @(posedge bck);
        ctrl_i <= 8'h40;
        check_idle(300);
        pcm_payload_test();
        block_test();
        stop_stream(200);
        pcm_payload_test();
        stop_stream(200);
        dsd_test();
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/audio_pkg.sv
hdl/i2s_master_clock.sv
hdl/i2s32_receiver.sv
hdl/dop_packer.sv
hdl/spdif_tx.sv
hdl/audio_bridge_top.sv
tests/audio_bridge_asserts.sv
tests/audio_bridge_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the audio bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module audio_bridge_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/Vaudio_bridge_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
